/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_dma_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Simulation FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
hdl/dma_pkg.sv
hdl/dma_bus_if.sv
hdl/dma_csr_if.sv
hdl/dma_reg_block.sv
hdl/dma_desc_fetch.sv
hdl/dma_memset_writer.sv
hdl/dma_core.sv
hdl/dma_top.sv
verification/tb_mem_model.sv
verification/tb_dma_top.sv

/* hdl/dma_bus_if.sv */
`timescale 1ns/1ps

interface dma_bus_if;

  logic                      a_valid;
  logic                      a_ready;
  logic                      a_write;
  logic [dma_pkg::ADDR_W-1:0] a_addr;
  logic [dma_pkg::DATA_W-1:0] a_wdata;

  logic                      d_valid;
  logic                      d_ready;
  logic [dma_pkg::DATA_W-1:0] d_rdata;

  modport master (
    output a_valid, a_write, a_addr, a_wdata, d_ready,
    input  a_ready, d_valid, d_rdata
  );

  modport slave (
    input  a_valid, a_write, a_addr, a_wdata, d_ready,
    output a_ready, d_valid, d_rdata
  );

endinterface

/* hdl/dma_core.sv */
`timescale 1ns/1ps

module dma_core (
  input  logic      clk_i,
  input  logic      rst_ni,
  dma_csr_if.core   csr,
  dma_bus_if.master host
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_WRITE,
    S_DRAIN,
    S_ERROR
  } state_e;

  state_e state_q;
  state_e state_d;

  dma_bus_if fetch_bus ();
  dma_bus_if write_bus ();

  logic                      start;
  logic                      fetch_done;
  logic                      wr_start;
  logic                      wr_done;
  logic [dma_pkg::DATA_W-1:0] desc_op;
  logic [dma_pkg::DATA_W-1:0] desc_len;
  logic [dma_pkg::DATA_W-1:0] desc_pattern;
  logic [dma_pkg::ADDR_W-1:0] desc_dst;

  // new jobs are only taken when nothing is running
  assign start    = csr.dadr_we && (state_q == S_IDLE || state_q == S_ERROR);
  assign wr_start = (state_q == S_FETCH) && fetch_done && !csr.abort &&
                    (desc_op == dma_pkg::OP_MEMSET) && (desc_len != '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE, S_ERROR: if (start) state_d = S_FETCH;
      S_FETCH: begin
        if (fetch_done) begin
          if (desc_op != dma_pkg::OP_MEMSET) state_d = S_ERROR;
          else if (desc_len == '0)           state_d = S_IDLE;
          else                               state_d = S_WRITE;
        end
      end
      S_WRITE: if (wr_done) state_d = S_IDLE;
      default: state_d = S_IDLE; // drain lasts one cycle
    endcase
    if (csr.abort) state_d = S_DRAIN;
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) state_q <= S_IDLE;
    else         state_q <= state_d;
  end

  always_comb begin
    case (state_q)
      S_FETCH: csr.status = dma_pkg::STATUS_READING_DESC;
      S_WRITE: csr.status = dma_pkg::STATUS_MEMSET_BUSY;
      S_ERROR: csr.status = dma_pkg::STATUS_ERROR;
      default: csr.status = dma_pkg::STATUS_IDLE;
    endcase
  end

  dma_desc_fetch u_fetch (
    .clk_i, .rst_ni, .start_i(start), .base_i(csr.dadr), .bus(fetch_bus),
    .op_o(desc_op), .length_o(desc_len), .pattern_o(desc_pattern), .dst_o(desc_dst),
    .done_o(fetch_done)
  );

  dma_memset_writer u_writer (
    .clk_i, .rst_ni, .start_i(wr_start), .abort_i(csr.abort), .length_i(desc_len),
    .pattern_i(desc_pattern), .dst_i(desc_dst), .bus(write_bus),
    .length_o(csr.length), .dst_o(csr.dst_adr), .done_o(wr_done)
  );

  assign csr.src_adr = desc_pattern; // SRC reports the fill pattern

  // host bus ownership follows the FSM, nobody drives it in idle or drain
  always_comb begin
    host.a_valid = (state_q == S_WRITE) ? write_bus.a_valid :
                   (state_q == S_FETCH) ? fetch_bus.a_valid : 1'b0;
    host.a_write = (state_q == S_WRITE) ? write_bus.a_write : fetch_bus.a_write;
    host.a_addr  = (state_q == S_WRITE) ? write_bus.a_addr  : fetch_bus.a_addr;
    host.a_wdata = (state_q == S_WRITE) ? write_bus.a_wdata : fetch_bus.a_wdata;
    host.d_ready = (state_q == S_WRITE) ? write_bus.d_ready :
                   (state_q == S_FETCH) ? fetch_bus.d_ready : 1'b1;
    fetch_bus.a_ready = host.a_ready && (state_q == S_FETCH);
    fetch_bus.d_valid = host.d_valid && (state_q == S_FETCH);
    fetch_bus.d_rdata = host.d_rdata;
    write_bus.a_ready = host.a_ready && (state_q == S_WRITE);
    write_bus.d_valid = host.d_valid && (state_q == S_WRITE);
    write_bus.d_rdata = host.d_rdata;
  end

  a_abort_to_idle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    csr.abort |=> (state_q == S_DRAIN) ##1 (state_q == S_IDLE)
  );

endmodule

/* hdl/dma_csr_if.sv */
`timescale 1ns/1ps

interface dma_csr_if;

  logic [dma_pkg::ADDR_W-1:0] dadr;
  logic                      dadr_we; // one cycle, new descriptor address
  logic                      abort;   // one cycle, nonzero CMD write

  dma_pkg::status_e          status;
  logic [dma_pkg::DATA_W-1:0] length;
  logic [dma_pkg::ADDR_W-1:0] src_adr;
  logic [dma_pkg::ADDR_W-1:0] dst_adr;

  modport regs (
    output dadr, dadr_we, abort,
    input  status, length, src_adr, dst_adr
  );

  modport core (
    input  dadr, dadr_we, abort,
    output status, length, src_adr, dst_adr
  );

endinterface

/* hdl/dma_desc_fetch.sv */
`timescale 1ns/1ps

module dma_desc_fetch (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  logic [dma_pkg::ADDR_W-1:0] base_i,

  dma_bus_if.master                 bus,

  output logic [dma_pkg::DATA_W-1:0] op_o,
  output logic [dma_pkg::DATA_W-1:0] length_o,
  output logic [dma_pkg::DATA_W-1:0] pattern_o,
  output logic [dma_pkg::ADDR_W-1:0] dst_o,
  output logic                      done_o
);

  logic                      a_valid_q;
  logic                      resp_wait_q;
  logic [1:0]                idx_q;
  logic [dma_pkg::ADDR_W-1:0] addr_q;
  logic                      done_q;
  logic                      d_fire;
  logic                      last_word;

  assign d_fire    = resp_wait_q && bus.d_valid;
  assign last_word = (idx_q == 2'(dma_pkg::DESC_WORDS - 1));

  // one read in flight at a time
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      a_valid_q   <= 1'b0;
      resp_wait_q <= 1'b0;
      idx_q       <= '0;
      addr_q      <= '0;
      done_q      <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        a_valid_q   <= 1'b1;
        resp_wait_q <= 1'b0;
        idx_q       <= '0;
        addr_q      <= base_i;
      end else begin
        if (a_valid_q && bus.a_ready) begin
          a_valid_q   <= 1'b0;
          resp_wait_q <= 1'b1;
        end
        if (d_fire) begin
          resp_wait_q <= 1'b0;
          if (last_word) begin
            done_q <= 1'b1;
          end else begin
            idx_q     <= idx_q + 2'd1;
            addr_q    <= addr_q + 32'd4; // next descriptor word
            a_valid_q <= 1'b1;
          end
        end
      end
    end
  end

  // each descriptor word lands in its own field
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      op_o      <= '0;
      length_o  <= '0;
      pattern_o <= '0;
      dst_o     <= '0;
    end else if (d_fire) begin
      case (idx_q)
        2'd0:    op_o      <= bus.d_rdata;
        2'd1:    length_o  <= bus.d_rdata;
        2'd2:    pattern_o <= bus.d_rdata;
        default: dst_o     <= bus.d_rdata;
      endcase
    end
  end

  assign bus.a_valid = a_valid_q;
  assign bus.a_write = 1'b0;
  assign bus.a_addr  = addr_q;
  assign bus.a_wdata = '0;
  assign bus.d_ready = 1'b1;
  assign done_o      = done_q;

  a_addr_stable_on_stall: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus.a_valid && !bus.a_ready && !start_i |=> $stable(bus.a_addr)
  );

endmodule

/* hdl/dma_memset_writer.sv */
`timescale 1ns/1ps

module dma_memset_writer (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  logic                      abort_i,
  input  logic [dma_pkg::DATA_W-1:0] length_i,
  input  logic [dma_pkg::DATA_W-1:0] pattern_i,
  input  logic [dma_pkg::ADDR_W-1:0] dst_i,

  dma_bus_if.master                 bus,

  output logic [dma_pkg::DATA_W-1:0] length_o,
  output logic [dma_pkg::ADDR_W-1:0] dst_o,
  output logic                      done_o
);

  logic                        busy_q;
  logic [dma_pkg::DATA_W-1:0]   req_left_q; // bytes not yet requested
  logic [dma_pkg::DATA_W-1:0]   ack_left_q; // bytes not yet acknowledged
  logic [dma_pkg::ADDR_W-1:0]   dst_q;
  logic [dma_pkg::DATA_W-1:0]   in_flight;
  logic [dma_pkg::DATA_W-3:0]   outstanding;
  logic                        a_fire;
  logic                        d_fire;

  // the gap between both counts is what is still on the bus
  assign in_flight   = ack_left_q - req_left_q;
  assign outstanding = in_flight[dma_pkg::DATA_W-1:2];

  assign bus.a_valid = busy_q && (req_left_q != '0) &&
                       (outstanding < dma_pkg::MAX_OUTSTANDING);
  assign bus.a_write = 1'b1;
  assign bus.a_addr  = dst_q;
  assign bus.a_wdata = pattern_i; // held by the fetch unit for the whole job
  assign bus.d_ready = 1'b1;

  assign a_fire = bus.a_valid && bus.a_ready;
  assign d_fire = bus.d_valid && bus.d_ready;
  assign done_o = busy_q && (req_left_q == '0) && (ack_left_q == '0);

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q     <= 1'b0;
      req_left_q <= '0;
      ack_left_q <= '0;
      dst_q      <= '0;
    end else if (abort_i) begin
      busy_q <= 1'b0; // counts freeze, late responses go nowhere
    end else if (start_i) begin
      busy_q     <= 1'b1;
      req_left_q <= length_i;
      ack_left_q <= length_i;
      dst_q      <= dst_i;
    end else begin
      if (a_fire) begin
        req_left_q <= req_left_q - 32'd4;
        dst_q      <= dst_q + 32'd4;
      end
      if (d_fire) begin
        ack_left_q <= ack_left_q - 32'd4;
      end
      if (done_o) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign length_o = req_left_q;
  assign dst_o    = dst_q;

  a_outstanding_limit: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    outstanding <= dma_pkg::MAX_OUTSTANDING
  );

  a_no_orphan_response: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    d_fire |-> outstanding != '0
  );

endmodule

/* hdl/dma_pkg.sv */
package dma_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;

  // software register byte offsets
  localparam logic [REG_ADDR_W-1:0] REG_NOW_DADR = 5'h00;
  localparam logic [REG_ADDR_W-1:0] REG_CMD      = 5'h04;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS   = 5'h08;
  localparam logic [REG_ADDR_W-1:0] REG_LENGTH   = 5'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_SRC      = 5'h10;
  localparam logic [REG_ADDR_W-1:0] REG_DST      = 5'h14;

  typedef enum logic [2:0] {
    STATUS_IDLE         = 3'd0,
    STATUS_READING_DESC = 3'd1,
    STATUS_MEMSET_BUSY  = 3'd2,
    STATUS_ERROR        = 3'd3
  } status_e;

  // only memset is implemented
  localparam logic [DATA_W-1:0] OP_MEMSET = '0;

  // op, length, pattern, dst
  localparam int DESC_WORDS = 4;

  localparam int MAX_OUTSTANDING = 4; // writes in flight

endpackage

/* hdl/dma_reg_block.sv */
`timescale 1ns/1ps

module dma_reg_block (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          reg_we_i,
  input  logic                          reg_re_i,
  input  logic [dma_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [dma_pkg::DATA_W-1:0]     reg_wdata_i,
  output logic [dma_pkg::DATA_W-1:0]     reg_rdata_o,

  dma_csr_if.regs                       csr
);

  logic [dma_pkg::ADDR_W-1:0] dadr_q;
  logic                      dadr_we_q;
  logic                      abort_q;
  logic [dma_pkg::DATA_W-1:0] rdata_q;
  logic [dma_pkg::DATA_W-1:0] rd_mux;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      dadr_q    <= '0;
      dadr_we_q <= 1'b0;
      abort_q   <= 1'b0;
    end else begin
      dadr_we_q <= 1'b0;
      abort_q   <= 1'b0;
      if (reg_we_i) begin
        if (reg_addr_i == dma_pkg::REG_NOW_DADR) begin
          dadr_q    <= reg_wdata_i;
          dadr_we_q <= 1'b1;
        end
        if (reg_addr_i == dma_pkg::REG_CMD && reg_wdata_i != '0) begin
          abort_q <= 1'b1; // any nonzero value aborts
        end
      end
    end
  end

  assign csr.dadr    = dadr_q;
  assign csr.dadr_we = dadr_we_q;
  assign csr.abort   = abort_q;

  always_comb begin
    rd_mux = '0; // unmapped offsets and CMD read as zero
    case (reg_addr_i)
      dma_pkg::REG_NOW_DADR: rd_mux = dadr_q;
      dma_pkg::REG_STATUS:   rd_mux = dma_pkg::DATA_W'(csr.status);
      dma_pkg::REG_LENGTH:   rd_mux = csr.length;
      dma_pkg::REG_SRC:      rd_mux = csr.src_adr;
      dma_pkg::REG_DST:      rd_mux = csr.dst_adr;
      default:               rd_mux = '0;
    endcase
  end

  // read data holds until the next read
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (reg_re_i) begin
      rdata_q <= rd_mux;
    end
  end

  assign reg_rdata_o = rdata_q;

  a_no_rw_same_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(reg_we_i && reg_re_i)
  );

endmodule

/* hdl/dma_top.sv */
`timescale 1ns/1ps

module dma_top (
  input  logic                          clk_i,
  input  logic                          rst_ni,

  input  logic                          reg_we_i,
  input  logic                          reg_re_i,
  input  logic [dma_pkg::REG_ADDR_W-1:0] reg_addr_i,
  input  logic [dma_pkg::DATA_W-1:0]     reg_wdata_i,
  output logic [dma_pkg::DATA_W-1:0]     reg_rdata_o,

  output logic                          host_a_valid_o,
  input  logic                          host_a_ready_i,
  output logic                          host_a_write_o,
  output logic [dma_pkg::ADDR_W-1:0]     host_a_addr_o,
  output logic [dma_pkg::DATA_W-1:0]     host_a_wdata_o,
  input  logic                          host_d_valid_i,
  output logic                          host_d_ready_o,
  input  logic [dma_pkg::DATA_W-1:0]     host_d_rdata_i
);

  dma_bus_if host_bus ();
  dma_csr_if csr ();

  dma_reg_block u_reg_block (
    .clk_i, .rst_ni, .reg_we_i, .reg_re_i, .reg_addr_i, .reg_wdata_i, .reg_rdata_o,
    .csr(csr)
  );

  dma_core u_core (.clk_i, .rst_ni, .csr(csr), .host(host_bus));

  assign host_a_valid_o   = host_bus.a_valid;
  assign host_a_write_o   = host_bus.a_write;
  assign host_a_addr_o    = host_bus.a_addr;
  assign host_a_wdata_o   = host_bus.a_wdata;
  assign host_d_ready_o   = host_bus.d_ready;
  assign host_bus.a_ready = host_a_ready_i;
  assign host_bus.d_valid = host_d_valid_i;
  assign host_bus.d_rdata = host_d_rdata_i;

endmodule

/* verification/tb_dma_top.sv */
`timescale 1ns/1ps

module tb_dma_top;

  localparam int JOB_TIMEOUT = 2000; // cycles

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic                           reg_we;
  logic                           reg_re;
  logic [dma_pkg::REG_ADDR_W-1:0] reg_addr;
  logic [31:0]                    reg_wdata;
  logic [31:0]                    reg_rdata;
  logic                           host_a_valid;
  logic                           host_a_ready;
  logic                           host_a_write;
  logic [31:0]                    host_a_addr;
  logic [31:0]                    host_a_wdata;
  logic                           host_d_valid;
  logic                           host_d_ready;
  logic [31:0]                    host_d_rdata;
  logic                           bd_we;
  logic [9:0]                     bd_addr;
  logic [31:0]                    bd_wdata;
  logic                           bus_quiet; // no request allowed while set
  int                             errors;
  int                             pass_cnt;
  int                             fail_cnt;
  int                             wr_count;

  always #20 clk = ~clk;

  dma_top u_dma_top (
    .clk_i(clk), .rst_ni(rst_n), .reg_we_i(reg_we), .reg_re_i(reg_re),
    .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
    .host_a_valid_o(host_a_valid), .host_a_ready_i(host_a_ready),
    .host_a_write_o(host_a_write), .host_a_addr_o(host_a_addr),
    .host_a_wdata_o(host_a_wdata), .host_d_valid_i(host_d_valid),
    .host_d_ready_o(host_d_ready), .host_d_rdata_i(host_d_rdata)
  );

  tb_mem_model u_mem (
    .clk_i(clk), .rst_ni(rst_n), .a_valid_i(host_a_valid), .a_ready_o(host_a_ready),
    .a_write_i(host_a_write), .a_addr_i(host_a_addr), .a_wdata_i(host_a_wdata),
    .d_valid_o(host_d_valid), .d_ready_i(host_d_ready), .d_rdata_o(host_d_rdata),
    .bd_we_i(bd_we), .bd_addr_i(bd_addr), .bd_wdata_i(bd_wdata)
  );

  always @(posedge clk) begin
    if (host_a_valid && host_a_ready && host_a_write) wr_count++;
  end

  a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    host_a_valid && !host_a_ready |=> !host_a_valid ||
      ($stable(host_a_addr) && $stable(host_a_wdata) && $stable(host_a_write)))
  else begin
    $display("host request changed while it was stalled at %0t", $time);
    errors++;
  end

  a_quiet_bus: assert property (@(posedge clk) disable iff (!rst_n)
    bus_quiet |-> !host_a_valid)
  else begin
    $display("host_a_valid went high while the DMA should be idle at %0t", $time);
    errors++;
  end

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s expected 0x%08h actual 0x%08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("check failed: %s", what);
      errors++;
    end
  endtask

  task automatic reg_write(input logic [4:0] addr, input logic [31:0] data);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we = 1'b0;
  endtask

  task automatic reg_read(input logic [4:0] addr, output logic [31:0] data);
    reg_re   = 1'b1;
    reg_addr = addr;
    @(negedge clk);
    reg_re = 1'b0;
    data   = reg_rdata; // registered read data is valid after one edge
  endtask

  task automatic mem_poke(input logic [9:0] idx, input logic [31:0] data);
    bd_we    = 1'b1;
    bd_addr  = idx;
    bd_wdata = data;
    @(negedge clk);
    bd_we = 1'b0;
  endtask

  function automatic logic [31:0] mem_peek(input logic [9:0] idx);
    return u_mem.mem[idx];
  endfunction

  task automatic write_desc(input logic [31:0] base, input logic [31:0] op,
                            input logic [31:0] len, input logic [31:0] pattern,
                            input logic [31:0] dst);
    mem_poke(base[11:2], op);
    mem_poke(base[11:2] + 10'd1, len);
    mem_poke(base[11:2] + 10'd2, pattern);
    mem_poke(base[11:2] + 10'd3, dst);
  endtask

  task automatic start_job(input logic [31:0] base);
    bus_quiet = 1'b0;
    wr_count  = 0;
    reg_write(dma_pkg::REG_NOW_DADR, base);
    @(negedge clk); // core leaves idle one edge after the strobe
  endtask

  task automatic wait_job_end(output logic [31:0] status, output logic saw_busy);
    int cycles;
    cycles   = 0;
    saw_busy = 1'b0;
    reg_read(dma_pkg::REG_STATUS, status);
    while ((status == 32'(dma_pkg::STATUS_READING_DESC) ||
            status == 32'(dma_pkg::STATUS_MEMSET_BUSY)) && cycles < JOB_TIMEOUT) begin
      if (status == 32'(dma_pkg::STATUS_MEMSET_BUSY)) saw_busy = 1'b1;
      reg_read(dma_pkg::REG_STATUS, status);
      cycles++;
    end
    check_true(cycles < JOB_TIMEOUT, "timeout, the job did not finish");
    bus_quiet = (cycles < JOB_TIMEOUT);
  endtask

  task automatic memset_job(input logic [31:0] base, input logic [31:0] dst,
                            input logic [31:0] len, input logic [31:0] pattern,
                            output logic saw_busy);
    logic [31:0] below;
    logic [31:0] above;
    logic [31:0] rd;
    logic [9:0]  first;
    int          words;
    first = dst[11:2];
    words = int'(len >> 2);
    below = mem_peek(first - 10'd1);
    above = mem_peek(first + 10'(words));
    write_desc(base, dma_pkg::OP_MEMSET, len, pattern, dst);
    start_job(base);
    wait_job_end(rd, saw_busy);
    check_eq("STATUS", 32'(dma_pkg::STATUS_IDLE), rd);
    check_eq("write count", len >> 2, wr_count);
    for (int i = 0; i < words; i++) begin
      check_eq($sformatf("mem[0x%03h]", first + 10'(i)), pattern, mem_peek(first + 10'(i)));
    end
    check_eq("word below range", below, mem_peek(first - 10'd1));
    check_eq("word above range", above, mem_peek(first + 10'(words)));
    reg_read(dma_pkg::REG_LENGTH, rd);
    check_eq("LENGTH", 32'h0, rd);
    reg_read(dma_pkg::REG_DST, rd);
    check_eq("DST", dst + len, rd);
    reg_read(dma_pkg::REG_SRC, rd);
    check_eq("SRC", pattern, rd);
  endtask

  task automatic no_write_job(input logic [31:0] base, input logic [31:0] op,
                              input logic [31:0] len, input dma_pkg::status_e exp);
    logic [31:0] prior;
    logic [31:0] rd;
    logic        saw_busy;
    prior = mem_peek(10'h180); // first word at dst 0x600
    write_desc(base, op, len, 32'hdead_beef, 32'h600);
    start_job(base);
    wait_job_end(rd, saw_busy);
    check_eq("STATUS", 32'(exp), rd);
    check_eq("write count", 32'h0, wr_count);
    check_eq("mem[0x180]", prior, mem_peek(10'h180));
  endtask

  task automatic abort_job();
    logic [31:0] rd;
    logic [31:0] last_prior;
    int          cycles;
    int          abort_cnt;
    last_prior = mem_peek(10'h37f); // last word of 0xc00 + 512
    write_desc(32'h180, dma_pkg::OP_MEMSET, 32'd512, 32'h0f0f_a5a5, 32'hc00);
    start_job(32'h180);
    cycles = 0;
    reg_read(dma_pkg::REG_STATUS, rd);
    while ((rd != 32'(dma_pkg::STATUS_MEMSET_BUSY) || wr_count < 8) &&
           cycles < JOB_TIMEOUT) begin
      reg_read(dma_pkg::REG_STATUS, rd);
      cycles++;
    end
    check_true(cycles < JOB_TIMEOUT, "timeout, the memset never got under way");
    reg_write(dma_pkg::REG_CMD, 32'h1);
    @(negedge clk);
    bus_quiet = 1'b1; // core sits in drain now
    abort_cnt = wr_count;
    reg_read(dma_pkg::REG_STATUS, rd);
    check_eq("STATUS", 32'(dma_pkg::STATUS_IDLE), rd);
    repeat (20) @(negedge clk); // late write responses come back here
    check_eq("mem[0x37f]", last_prior, mem_peek(10'h37f));
    check_eq("write count after abort", abort_cnt, wr_count);
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (errors == err_before) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic        saw_busy;
    int          err0;
    errors    = 0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    wr_count  = 0;
    bus_quiet = 1'b1;
    reg_we    = 1'b0;
    reg_re    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    bd_we     = 1'b0;
    bd_addr   = '0;
    bd_wdata  = '0;
    rst_n     = 1'b0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    err0 = errors;
    check_eq("host_a_valid_o", 32'h0, 32'(host_a_valid));
    check_eq("host_d_ready_o", 32'h1, 32'(host_d_ready));
    for (int off = 0; off < 24; off += 4) begin
      reg_read(5'(off), rd); // STATUS_IDLE is zero too
      check_eq($sformatf("register 0x%02h", off), 32'h0, rd);
    end
    finish_test("reset values", err0);

    err0 = errors;
    memset_job(32'h100, 32'h400, 32'd32, 32'h1234_abcd, saw_busy);
    finish_test("memset 32 bytes", err0);

    err0 = errors;
    memset_job(32'h140, 32'h800, 32'd256, 32'h5a5a_0ff0, saw_busy);
    check_true(saw_busy, "STATUS never read MEMSET_BUSY during the long memset");
    finish_test("long memset under stalls", err0);

    err0 = errors;
    no_write_job(32'h1c0, 32'h1, 32'd16, dma_pkg::STATUS_ERROR);
    finish_test("unknown operation", err0);

    err0 = errors;
    no_write_job(32'h1e0, 32'h0, 32'd0, dma_pkg::STATUS_IDLE);
    finish_test("zero length", err0);

    err0 = errors;
    abort_job();
    finish_test("abort", err0);

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (errors == 0 && fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* verification/tb_mem_model.sv */
`timescale 1ns/1ps

module tb_mem_model (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        a_valid_i,
  output logic        a_ready_o,
  input  logic        a_write_i,
  input  logic [31:0] a_addr_i,
  input  logic [31:0] a_wdata_i,
  output logic        d_valid_o,
  input  logic        d_ready_i,
  output logic [31:0] d_rdata_o,
  input  logic        bd_we_i,    // backdoor write, places descriptors
  input  logic [9:0]  bd_addr_i,  // word index
  input  logic [31:0] bd_wdata_i
);

  logic [31:0] mem [1024];
  logic [31:0] rsp_data_q [$]; // responses in request order
  int unsigned rsp_due_q [$];  // cycle from which each response may leave
  int unsigned cycle;

  initial begin
    void'($urandom(32'hd8b4));
    for (int i = 0; i < 1024; i++) begin
      mem[i] = {16'hc0de, 4'h0, 10'(i), 2'b00}; // carries its own byte address
    end
    cycle = 0;
    a_ready_o <= 1'b0;
    d_valid_o <= 1'b0;
    d_rdata_o <= '0;
    forever begin
      @(posedge clk_i);
      if (!rst_ni) begin
        rsp_data_q.delete();
        rsp_due_q.delete();
        a_ready_o <= 1'b0;
        d_valid_o <= 1'b0;
      end else begin
        cycle++;
        if (d_valid_o && d_ready_i) begin
          rsp_data_q.delete(0);
          rsp_due_q.delete(0);
        end
        if (a_valid_i && a_ready_o) begin
          if (a_write_i) mem[a_addr_i[11:2]] = a_wdata_i;
          rsp_data_q.push_back(a_write_i ? a_wdata_i : mem[a_addr_i[11:2]]);
          rsp_due_q.push_back(cycle + $urandom_range(3, 0)); // 0 to 3 extra cycles
        end
        if (bd_we_i) mem[bd_addr_i] = bd_wdata_i;
        a_ready_o <= ($urandom_range(3, 0) != 0); // stall about one cycle in four
        if (rsp_data_q.size() != 0 && rsp_due_q[0] <= cycle) begin
          d_valid_o <= 1'b1;
          d_rdata_o <= rsp_data_q[0];
        end else begin
          d_valid_o <= 1'b0;
        end
      end
    end
  end

endmodule
